/* Makefile */
# Verilator flow for the core-local control block

VERILATOR ?= verilator
FILELIST  ?= clint_ctrl.f
TB_TOP    ?= tb_clint_ctrl
RTL_TOP   ?= clint_ctrl_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timescale 1ns/1ps --assert
FAIL_MSG  ?= STATUS: FAIL
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
	   -Mdir $(BUILD_DIR) -o V$(TB_TOP)

# The simulator exit code is ignored here, the log decides
sim: build
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* clint_ctrl.f */
rtl/mmr_pkg.sv
rtl/ctrl_pkg.sv
rtl/mmr_decode.sv
rtl/machine_timer.sv
rtl/pipe_ctrl.sv
rtl/clint_ctrl_top.sv
dv/tb_clint_ctrl.sv

/* dv/tb_clint_ctrl.sv */
// Testbench for the core-local control top level with stimulus table, checks and timeouts
`timescale 1ns/1ps

module tb_clint_ctrl;
   import mmr_pkg::*;

   localparam logic [ADDR_W-1:0] BASE = 32'h0200_0000;
   localparam int N_REDIR = 32;                           // Random redirect entries

   typedef enum logic [1:0] {OP_IDLE, OP_WR, OP_RD, OP_REDIR} op_e;

   typedef struct packed
   {
      op_e               op;
      logic [ADDR_W-1:0] addr;                            // MMR address or write-back PC
      logic [XLEN-1:0]   data;                            // Store data or execute PC
      logic [XLEN-1:0]   exp;                             // Expected load data
      logic              fault;
      logic [2:0]        flags;                           // {wb_pc, wb_ic, exe_pc}
   } entry_t;

   logic              clk_in = 1'b0;
   logic              rst_n = 1'b0;
   logic              mmr_req = 1'b0;
   logic              mmr_wr = 1'b0;
   logic [ADDR_W-1:0] mmr_addr = '0;
   logic [XLEN-1:0]   mmr_wr_data = '0;
   logic              wb_rld_pc_flag = 1'b0;
   logic              wb_rld_ic_flag = 1'b0;
   logic              exe_rld_pc_flag = 1'b0;
   logic [ADDR_W-1:0] wb_rld_pc_addr = '0;
   logic [ADDR_W-1:0] exe_rld_pc_addr = '0;
   logic              trigger_wfi = 1'b0;
   logic              ext_irq = 1'b0;
   logic              mmr_ack, mmr_fault, pc_reload, ic_reload;
   logic [XLEN-1:0]   mmr_rd_data;
   logic [ADDR_W-1:0] pc_reload_addr;
   logic              flush_dec, flush_exe, flush_mem, cpu_halt, timer_irq, sw_irq;

   entry_t            tbl[$];                             // Stimulus table
   integer            seed = 28;

   always #10 clk_in = ~clk_in;                           // 20 ns period

   clint_ctrl_top #(.MMR_BASE(BASE)) i_clint_ctrl_top (.*);

   // ------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------
   task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
      if (got !== exp)
      begin
         $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("timeout at %0t ns while waiting for %s", $time, what);
      $display("STATUS: FAIL");
      $fatal(1, "wait limit exceeded");
   endtask

   function automatic logic [ADDR_W-1:0] reg_addr(input mmr_reg_e r);
      logic [OFS_W-1:0] ofs;
      case (r)
         REG_MSIP:        ofs = OFS_MSIP;
         REG_MTIMECMP_LO: ofs = OFS_MTIMECMP_LO;
         REG_MTIMECMP_HI: ofs = OFS_MTIMECMP_HI;
         REG_MTIME_LO:    ofs = OFS_MTIME_LO;
         REG_MTIME_HI:    ofs = OFS_MTIME_HI;
         default:         ofs = 16'h0008;                 // Hole in the map
      endcase
      return {BASE[ADDR_W-1:OFS_W], ofs};
   endfunction

   task automatic add_entry(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] exp, input logic fault);
      tbl.push_back('{op, addr, data, exp, fault, 3'b000});
   endtask

   // Entry goes onto the pins at a rising edge
   task automatic drive(input entry_t e);
      mmr_req         <= (e.op == OP_WR) || (e.op == OP_RD);
      mmr_wr          <= (e.op == OP_WR);
      mmr_addr        <= e.addr;
      mmr_wr_data     <= e.data;
      wb_rld_pc_flag  <= (e.op == OP_REDIR) && e.flags[2];
      wb_rld_ic_flag  <= (e.op == OP_REDIR) && e.flags[1];
      exe_rld_pc_flag <= (e.op == OP_REDIR) && e.flags[0];
      wb_rld_pc_addr  <= e.addr;
      exe_rld_pc_addr <= e.data;
   endtask

   task automatic check_redirect(input entry_t e);
      logic any;
      any = e.flags[2] | e.flags[0];                      // Either stage reloads
      check(64'(pc_reload), 64'(any), "pc_reload");
      check(64'(pc_reload_addr), 64'(e.flags[2] ? e.addr : e.data), "pc_reload_addr");
      check(64'(ic_reload), 64'(e.flags[1]), "ic_reload");
      check(64'(flush_dec), 64'(any), "flush_dec");
      check(64'(flush_exe), 64'(any), "flush_exe");
      check(64'(flush_mem), 64'(e.flags[2]), "flush_mem");  // Write-back only
   endtask

   // Back-to-back entries, each ack checked one cycle after its request
   task automatic run_table();
      entry_t cur;
      entry_t prev;
      logic   prev_mmr;
      prev     = '0;
      prev_mmr = 1'b0;
      for (int i = 0; i <= tbl.size(); i++)
      begin
         cur = '0;                                        // Idle after the last entry
         if (i < tbl.size())
            cur = tbl[i];
         @(posedge clk_in);
         drive(cur);
         @(negedge clk_in);
         check(64'(mmr_ack), 64'(prev_mmr), "ack one cycle after request");
         if (prev_mmr)
            check(64'(mmr_fault), 64'(prev.fault), "fault flag");
         if (prev_mmr && prev.op == OP_RD)
            check(64'(mmr_rd_data), 64'(prev.exp), "read data");
         if (cur.op == OP_REDIR)
            check_redirect(cur);
         prev     = cur;
         prev_mmr = (cur.op == OP_WR) || (cur.op == OP_RD);
      end
   endtask

   task automatic mmr_write(input mmr_reg_e r, input logic [XLEN-1:0] data);
      @(posedge clk_in);
      drive('{OP_WR, reg_addr(r), data, 32'h0, 1'b0, 3'b000});
      @(posedge clk_in);
      drive('0);
      @(negedge clk_in);                                  // Ack cycle
      check(64'(mmr_ack), 64'd1, "write ack");
      check(64'(mmr_fault), 64'd0, "write fault");
   endtask

   task automatic pulse_wfi_or_irq(input logic wfi);
      @(posedge clk_in);
      if (wfi)
         trigger_wfi <= 1'b1;
      else
         ext_irq <= 1'b1;
      @(posedge clk_in);
      trigger_wfi <= 1'b0;
      ext_irq     <= 1'b0;
      @(negedge clk_in);                                  // Cycle after the pulse
   endtask

   // ------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------
   initial
   begin
      int              n;
      logic [31:0]     wb_pc, exe_pc, r;
      logic [XLEN-1:0] sw_vals [4];
      repeat (3) @(posedge clk_in);
      rst_n <= 1'b1;
      @(negedge clk_in);
      check(64'(cpu_halt), 64'd0, "cpu_halt after reset");
      check(64'(timer_irq), 64'd0, "timer_irq after reset");
      check(64'(sw_irq), 64'd0, "sw_irq after reset");

      add_entry(OP_RD, reg_addr(REG_MTIMECMP_LO), '0, 32'hFFFF_FFFF, 1'b0);
      add_entry(OP_RD, reg_addr(REG_MTIMECMP_HI), '0, 32'hFFFF_FFFF, 1'b0);
      add_entry(OP_RD, reg_addr(REG_MSIP), '0, '0, 1'b0);
      add_entry(OP_WR, reg_addr(REG_MTIMECMP_LO), 32'h1234_5678, '0, 1'b0);
      add_entry(OP_WR, reg_addr(REG_MTIMECMP_HI), 32'h9ABC_DEF0, '0, 1'b0);
      add_entry(OP_RD, reg_addr(REG_MTIMECMP_LO), '0, 32'h1234_5678, 1'b0);
      add_entry(OP_RD, reg_addr(REG_MTIMECMP_HI), '0, 32'h9ABC_DEF0, 1'b0);
      add_entry(OP_WR, reg_addr(REG_MSIP), 32'hFFFF_FFFF, '0, 1'b0);
      add_entry(OP_RD, reg_addr(REG_MSIP), '0, 32'h1, 1'b0);  // Only bit 0 kept
      add_entry(OP_WR, reg_addr(REG_MSIP), '0, '0, 1'b0);
      add_entry(OP_WR, reg_addr(REG_MTIME_LO), 32'h0000_1000, '0, 1'b0);
      add_entry(OP_RD, reg_addr(REG_MTIME_LO), '0, 32'h0000_1000, 1'b0);
      add_entry(OP_RD, reg_addr(REG_NONE), '0, '0, 1'b1);     // Unmapped offset
      add_entry(OP_WR, BASE | 32'h1234, 32'h1, '0, 1'b1);
      add_entry(OP_WR, 32'h0300_0000, 32'h1, '0, 1'b1);       // Wrong base, msip spot
      add_entry(OP_RD, 32'h0300_4000, '0, '0, 1'b1);
      add_entry(OP_RD, reg_addr(REG_MSIP), '0, '0, 1'b0);     // Faulted store ignored
      for (int i = 0; i < N_REDIR; i++)
      begin
         r      = $random(seed);
         wb_pc  = $random(seed);
         exe_pc = $random(seed);
         tbl.push_back('{OP_REDIR, wb_pc, exe_pc, 32'h0, 1'b0, r[2:0]});
      end
      run_table();

      // Timer irq from a cleared mtime against a compare of 40
      mmr_write(REG_MTIME_HI, '0);
      mmr_write(REG_MTIME_LO, '0);
      mmr_write(REG_MTIMECMP_LO, 32'd40);
      mmr_write(REG_MTIMECMP_HI, '0);
      n = 4;                                              // Cycles since mtime cleared
      while (!timer_irq)
      begin
         if (n >= 100)
            timeout_fail("timer_irq to rise");
         @(negedge clk_in);
         n++;
      end
      check(64'(n), 64'd41, "timer_irq rise cycle");  // Compare hit at 40, one register
      mmr_write(REG_MTIMECMP_HI, '1);
      n = 0;
      while (timer_irq)
      begin
         if (n >= 2)
            timeout_fail("timer_irq to clear");
         @(negedge clk_in);
         n++;
      end

      sw_vals = '{32'h1, 32'hFFFF_FFFE, 32'h3, 32'h0};
      foreach (sw_vals[k])
      begin
         mmr_write(REG_MSIP, sw_vals[k]);
         check(64'(sw_irq), 64'(sw_vals[k][0]), "sw_irq follows msip");
      end

      // ------------------------------------------------------------------
      // Halt and wake
      // ------------------------------------------------------------------
      pulse_wfi_or_irq(1'b1);
      check(64'(cpu_halt), 64'd1, "halt after wfi");
      pulse_wfi_or_irq(1'b0);
      check(64'(cpu_halt), 64'd0, "wake on ext_irq");
      pulse_wfi_or_irq(1'b1);
      check(64'(cpu_halt), 64'd1, "second halt");
      mmr_write(REG_MSIP, 32'h1);
      n = 0;
      while (cpu_halt)
      begin
         if (n >= 2)
            timeout_fail("cpu_halt to clear after msip write");
         @(negedge clk_in);
         n++;
      end
      pulse_wfi_or_irq(1'b1);                             // Wake pending, no halt
      check(64'(cpu_halt), 64'd0, "wfi with msip set");
      mmr_write(REG_MSIP, '0);

      $display("STATUS: PASS");
      $finish;
   end

endmodule

/* rtl/clint_ctrl_top.sv */
// Core-local control top level joining the MMR decoder, machine timer and pipeline control
`timescale 1ns/1ps

module clint_ctrl_top
#(
   parameter logic [mmr_pkg::ADDR_W-1:0] MMR_BASE = 32'h0200_0000  // Register block base
)
(
   input  logic                        clk_in,
   input  logic                        rst_n,

   // MMR access from the memory stage
   input  logic                        mmr_req,
   input  logic                        mmr_wr,
   input  logic [mmr_pkg::ADDR_W-1:0]  mmr_addr,
   input  logic [mmr_pkg::XLEN-1:0]    mmr_wr_data,
   output logic                        mmr_ack,
   output logic                        mmr_fault,
   output logic [mmr_pkg::XLEN-1:0]    mmr_rd_data,

   // Redirects from write-back and execute
   input  logic                        wb_rld_pc_flag,
   input  logic                        wb_rld_ic_flag,
   input  logic [mmr_pkg::ADDR_W-1:0]  wb_rld_pc_addr,
   input  logic                        exe_rld_pc_flag,
   input  logic [mmr_pkg::ADDR_W-1:0]  exe_rld_pc_addr,

   input  logic                        trigger_wfi,
   input  logic                        ext_irq,

   // Pipeline control
   output logic                        pc_reload,
   output logic                        ic_reload,
   output logic [mmr_pkg::ADDR_W-1:0]  pc_reload_addr,
   output logic                        flush_dec,
   output logic                        flush_exe,
   output logic                        flush_mem,
   output logic                        cpu_halt,

   // Interrupt levels
   output logic                        timer_irq,
   output logic                        sw_irq
);
   import mmr_pkg::*;

   logic              msip_wr, mtimecmp_lo_wr, mtimecmp_hi_wr;   // Decoder to timer
   logic              mtime_lo_wr, mtime_hi_wr;
   logic [TIME_W-1:0] mtime, mtimecmp;                    // Timer to read mux
   logic              msip;

   mmr_decode #(.MMR_BASE(MMR_BASE)) i_mmr_decode
   (
      .clk_in, .rst_n, .mmr_req, .mmr_wr, .mmr_addr, .mmr_wr_data,
      .mtime, .mtimecmp, .msip,
      .msip_wr, .mtimecmp_lo_wr, .mtimecmp_hi_wr, .mtime_lo_wr, .mtime_hi_wr,
      .mmr_ack, .mmr_fault, .mmr_rd_data
   );

   machine_timer i_machine_timer
   (
      .clk_in, .rst_n,
      .msip_wr, .mtimecmp_lo_wr, .mtimecmp_hi_wr, .mtime_lo_wr, .mtime_hi_wr,
      .mmr_wr_data, .mtime, .mtimecmp, .msip, .timer_irq, .sw_irq
   );

   // Redirects and halt, woken by either timer level or ext_irq
   pipe_ctrl i_pipe_ctrl
   (
      .clk_in, .rst_n,
      .wb_rld_pc_flag, .wb_rld_ic_flag, .wb_rld_pc_addr, .exe_rld_pc_flag, .exe_rld_pc_addr,
      .trigger_wfi, .ext_irq, .timer_irq, .sw_irq,
      .pc_reload, .ic_reload, .pc_reload_addr, .flush_dec, .flush_exe, .flush_mem,
      .cpu_halt
   );

endmodule

/* rtl/ctrl_pkg.sv */
// Redirect source and halt state enums for the pipeline control
package ctrl_pkg;

   // ------------------------------------------------------------------
   // Redirect source
   // ------------------------------------------------------------------
   // Write-back outranks execute, NONE when neither stage asks for a
   // PC reload in the current cycle
   typedef enum logic [1:0]
   {
      REDIR_NONE,                              // No redirect this cycle
      REDIR_EXE,                               // Branch mispredict from execute
      REDIR_WB                                 // Trap / fence / return from write-back
   } redirect_src_e;

   // ------------------------------------------------------------------
   // Halt state
   // ------------------------------------------------------------------
   // ST_HALT is entered by a WFI and left on any interrupt level
   typedef enum logic
   {
      ST_RUN,                                  // Core fetching and executing
      ST_HALT                                  // Core asleep
   } halt_state_e;

endpackage

/* rtl/machine_timer.sv */
// Machine timer with mtime, mtimecmp, msip and the timer and software interrupt levels
`timescale 1ns/1ps

module machine_timer
(
   input  logic                        clk_in,
   input  logic                        rst_n,

   // Write strobes from the MMR decoder, valid in the request cycle
   input  logic                        msip_wr,
   input  logic                        mtimecmp_lo_wr,
   input  logic                        mtimecmp_hi_wr,
   input  logic                        mtime_lo_wr,
   input  logic                        mtime_hi_wr,
   input  logic [mmr_pkg::XLEN-1:0]    mmr_wr_data,       // Shared store data

   // Register contents for the read multiplexer
   output logic [mmr_pkg::TIME_W-1:0]  mtime,
   output logic [mmr_pkg::TIME_W-1:0]  mtimecmp,
   output logic                        msip,

   // Interrupt levels
   output logic                        timer_irq,         // Registered compare result
   output logic                        sw_irq             // Straight from msip
);
   import mmr_pkg::*;

   logic              time_hit;                           // mtime has reached mtimecmp

   // ------------------------------------------------------------------
   // Free-running mtime
   // ------------------------------------------------------------------
   // A half write replaces the increment for that edge
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         mtime <= '0;
      else if (mtime_lo_wr)
         mtime[XLEN-1:0] <= mmr_wr_data;                  // High half holds
      else if (mtime_hi_wr)
         mtime[TIME_W-1:XLEN] <= mmr_wr_data;             // Low half holds
      else
         mtime <= mtime + TIME_W'(1);
   end

   // ------------------------------------------------------------------
   // Compare register and software pending bit
   // ------------------------------------------------------------------
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         mtimecmp <= '1;                                  // Far future, no irq
         msip     <= 1'b0;
      end
      else
      begin
         if (mtimecmp_lo_wr)
            mtimecmp[XLEN-1:0] <= mmr_wr_data;
         if (mtimecmp_hi_wr)
            mtimecmp[TIME_W-1:XLEN] <= mmr_wr_data;
         if (msip_wr)
            msip <= mmr_wr_data[0];                       // Upper bits dropped
      end
   end

   // Unsigned 64-bit compare
   assign time_hit = (mtime >= mtimecmp);

   // Timer irq one cycle behind the compare
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         timer_irq <= 1'b0;
      else
         timer_irq <= time_hit;
   end

   assign sw_irq = msip;

   // mtime only moves backwards through a store, wrap excluded
   a_mtime_mono: assert property (@(posedge clk_in) disable iff (!rst_n)
      (!mtime_lo_wr && !mtime_hi_wr && (mtime != '1)) |=> (mtime >= $past(mtime)));

endmodule

/* rtl/mmr_decode.sv */
// MMR address decode, write strobes, read multiplexer and registered acknowledge
`timescale 1ns/1ps

module mmr_decode
#(
   parameter logic [mmr_pkg::ADDR_W-1:0] MMR_BASE = 32'h0200_0000  // 64 KiB aligned
)
(
   input  logic                        clk_in,
   input  logic                        rst_n,

   // Strobe request from the memory stage
   input  logic                        mmr_req,           // One-cycle request pulse
   input  logic                        mmr_wr,            // 1 = store, 0 = load
   input  logic [mmr_pkg::ADDR_W-1:0]  mmr_addr,
   input  logic [mmr_pkg::XLEN-1:0]    mmr_wr_data,

   // Current register contents for loads
   input  logic [mmr_pkg::TIME_W-1:0]  mtime,
   input  logic [mmr_pkg::TIME_W-1:0]  mtimecmp,
   input  logic                        msip,

   // Write strobes to the timer block
   output logic                        msip_wr,
   output logic                        mtimecmp_lo_wr,
   output logic                        mtimecmp_hi_wr,
   output logic                        mtime_lo_wr,
   output logic                        mtime_hi_wr,

   // Acknowledge, one cycle after the request
   output logic                        mmr_ack,
   output logic                        mmr_fault,
   output logic [mmr_pkg::XLEN-1:0]    mmr_rd_data
);
   import mmr_pkg::*;

   mmr_reg_e          reg_sel;                            // Decoded target register
   logic              base_hit;                           // Upper address bits match
   logic              wr_hit;                             // Store to a mapped register
   logic [XLEN-1:0]   rd_mux;                             // Load data for this request

   // ------------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------------
   assign base_hit = (mmr_addr[ADDR_W-1:OFS_W] == MMR_BASE[ADDR_W-1:OFS_W]);

   always_comb
   begin
      reg_sel = REG_NONE;
      if (base_hit)
      begin
         case (mmr_addr[OFS_W-1:0])
            OFS_MSIP:        reg_sel = REG_MSIP;
            OFS_MTIMECMP_LO: reg_sel = REG_MTIMECMP_LO;
            OFS_MTIMECMP_HI: reg_sel = REG_MTIMECMP_HI;
            OFS_MTIME_LO:    reg_sel = REG_MTIME_LO;
            OFS_MTIME_HI:    reg_sel = REG_MTIME_HI;
            default:         reg_sel = REG_NONE;          // Hole in the map
         endcase
      end
   end

   // Strobes only for stores that hit, faults write nothing
   assign wr_hit         = mmr_req & mmr_wr;
   assign msip_wr        = wr_hit & (reg_sel == REG_MSIP);
   assign mtimecmp_lo_wr = wr_hit & (reg_sel == REG_MTIMECMP_LO);
   assign mtimecmp_hi_wr = wr_hit & (reg_sel == REG_MTIMECMP_HI);
   assign mtime_lo_wr    = wr_hit & (reg_sel == REG_MTIME_LO);
   assign mtime_hi_wr    = wr_hit & (reg_sel == REG_MTIME_HI);

   // ------------------------------------------------------------------
   // Read path
   // ------------------------------------------------------------------
   always_comb
   begin
      case (reg_sel)
         REG_MSIP:        rd_mux = {{(XLEN-1){1'b0}}, msip};  // Zero-extended
         REG_MTIMECMP_LO: rd_mux = mtimecmp[XLEN-1:0];
         REG_MTIMECMP_HI: rd_mux = mtimecmp[TIME_W-1:XLEN];
         REG_MTIME_LO:    rd_mux = mtime[XLEN-1:0];
         REG_MTIME_HI:    rd_mux = mtime[TIME_W-1:XLEN];
         default:         rd_mux = '0;                    // Fault returns zero
      endcase
   end

   // Acknowledge and fault flags
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         mmr_ack   <= 1'b0;
         mmr_fault <= 1'b0;
      end
      else
      begin
         mmr_ack   <= mmr_req;
         mmr_fault <= mmr_req & (reg_sel == REG_NONE);
      end
   end

   // Load data captured in the request cycle, stores return zero
   always_ff @(posedge clk_in)
   begin
      if (mmr_req)
         mmr_rd_data <= mmr_wr ? '0 : rd_mux;
   end

   // Only one timer register can be targeted per request
   a_onehot_wr: assert property (@(posedge clk_in) disable iff (!rst_n)
      $onehot0({msip_wr, mtimecmp_lo_wr, mtimecmp_hi_wr, mtime_lo_wr, mtime_hi_wr}));

endmodule

/* rtl/mmr_pkg.sv */
// Register map offsets, data widths and the MMR register select enum
package mmr_pkg;

   // ------------------------------------------------------------------
   // Data widths
   // ------------------------------------------------------------------
   localparam int XLEN   = 32;                 // Core data width
   localparam int ADDR_W = 32;                 // Load/store address width
   localparam int TIME_W = 64;                 // mtime / mtimecmp width

   // Offset field inside the 64 KiB register window
   localparam int OFS_W  = 16;

   // ------------------------------------------------------------------
   // Register offsets relative to the block base
   // ------------------------------------------------------------------
   localparam logic [OFS_W-1:0] OFS_MSIP        = 16'h0000;  // Software irq pending
   localparam logic [OFS_W-1:0] OFS_MTIMECMP_LO = 16'h4000;  // Compare, low word
   localparam logic [OFS_W-1:0] OFS_MTIMECMP_HI = 16'h4004;  // Compare, high word
   localparam logic [OFS_W-1:0] OFS_MTIME_LO    = 16'hBFF8;  // Timer, low word
   localparam logic [OFS_W-1:0] OFS_MTIME_HI    = 16'hBFFC;  // Timer, high word

   // ------------------------------------------------------------------
   // Decoded register select
   // ------------------------------------------------------------------
   // REG_NONE covers a wrong base as well as an unmapped offset
   typedef enum logic [2:0]
   {
      REG_NONE,
      REG_MSIP,
      REG_MTIMECMP_LO,
      REG_MTIMECMP_HI,
      REG_MTIME_LO,
      REG_MTIME_HI
   } mmr_reg_e;

endpackage

/* rtl/pipe_ctrl.sv */
// Redirect arbitration, pipeline stage flushes and the halt/wake FSM
`timescale 1ns/1ps

module pipe_ctrl
(
   input  logic                        clk_in,
   input  logic                        rst_n,

   // Redirect requests
   input  logic                        wb_rld_pc_flag,    // Write-back reload
   input  logic                        wb_rld_ic_flag,    // Store hit the I$ space
   input  logic [mmr_pkg::ADDR_W-1:0]  wb_rld_pc_addr,
   input  logic                        exe_rld_pc_flag,   // Branch mispredict
   input  logic [mmr_pkg::ADDR_W-1:0]  exe_rld_pc_addr,

   // Halt and wake sources
   input  logic                        trigger_wfi,       // WFI pulse from write-back
   input  logic                        ext_irq,           // Level
   input  logic                        timer_irq,
   input  logic                        sw_irq,

   // Fetch reload
   output logic                        pc_reload,
   output logic                        ic_reload,
   output logic [mmr_pkg::ADDR_W-1:0]  pc_reload_addr,

   // Stage flushes
   output logic                        flush_dec,
   output logic                        flush_exe,
   output logic                        flush_mem,

   output logic                        cpu_halt
);
   import ctrl_pkg::*;

   redirect_src_e     redir_src;                          // Winning redirect
   halt_state_e       halt_state;
   halt_state_e       halt_next;
   logic              wake;                               // Any interrupt level

   // ------------------------------------------------------------------
   // Redirect arbitration
   // ------------------------------------------------------------------
   always_comb
   begin
      if (wb_rld_pc_flag)
         redir_src = REDIR_WB;                            // Older instruction wins
      else if (exe_rld_pc_flag)
         redir_src = REDIR_EXE;
      else
         redir_src = REDIR_NONE;
   end

   assign pc_reload      = (redir_src != REDIR_NONE);
   assign pc_reload_addr = (redir_src == REDIR_WB) ? wb_rld_pc_addr : exe_rld_pc_addr;
   assign ic_reload      = wb_rld_ic_flag;

   // Mispredict clears up to execute, write-back also clears memory
   assign flush_dec = pc_reload;
   assign flush_exe = pc_reload;
   assign flush_mem = (redir_src == REDIR_WB);

   // ------------------------------------------------------------------
   // Halt and wake
   // ------------------------------------------------------------------
   assign wake = ext_irq | timer_irq | sw_irq;

   always_comb
   begin
      halt_next = halt_state;
      if (wake)
         halt_next = ST_RUN;                              // Wake beats WFI
      else if (trigger_wfi)
         halt_next = ST_HALT;
   end

   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         halt_state <= ST_RUN;
      else
         halt_state <= halt_next;
   end

   assign cpu_halt = (halt_state == ST_HALT);

   a_flush_order: assert property (@(posedge clk_in) disable iff (!rst_n)
      flush_mem |-> flush_exe);

   // A pending interrupt never leaves the core asleep
   a_wake: assert property (@(posedge clk_in) disable iff (!rst_n)
      wake |=> !cpu_halt);

endmodule
